//--- compile.f
source/fmul_pkg.sv
source/fmul_unpack.sv
source/fmul_normalize.sv
source/fmul_round_decide.sv
source/fmul_pack.sv
source/fmul_top.sv
verif/fmul_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FMUL testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module fmul_tb -f compile.f -o fmul_sim

output=$(./obj_dir/fmul_sim)
echo "$output"

if echo "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1

//--- source/fmul_normalize.sv
module fmul_normalize (
  input  fmul_pkg::product_stage_t i_product,
  output fmul_pkg::lzc_stage_t     o_lzc_stage,
  input  fmul_pkg::lzc_stage_t     i_lzc_stage,
  output fmul_pkg::norm_stage_t    o_norm_stage
);

  // ======================================================================
  // Leading-zero count, from the stage 3 register
  // ======================================================================

  fmul_pkg::lzc_t lzc;

  // Zeros counted from bit 46 down, the highest set bit wins
  always_comb begin
    lzc = '0;
    for (int i = 0; i < 47; i++) begin
      if (i_product.prod[i]) begin
        lzc = fmul_pkg::lzc_t'(46 - i);
      end
    end
  end

  always_comb begin
    o_lzc_stage.base      = i_product;
    o_lzc_stage.prod_zero = (i_product.prod == '0);
    o_lzc_stage.msb_set   = i_product.prod[47];
    o_lzc_stage.lzc       = lzc;
  end

  // ======================================================================
  // Normalization shift, from the stage 3B register
  // ======================================================================

  always_comb begin
    o_norm_stage.sign            = i_lzc_stage.base.sign;
    o_norm_stage.prod_zero       = i_lzc_stage.prod_zero;
    o_norm_stage.special         = i_lzc_stage.base.special;
    o_norm_stage.special_result  = i_lzc_stage.base.special_result;
    o_norm_stage.special_invalid = i_lzc_stage.base.special_invalid;
    o_norm_stage.rm              = i_lzc_stage.base.rm;

    if (i_lzc_stage.prod_zero) begin
      o_norm_stage.prod = '0;
      o_norm_stage.exp  = '0;
    end else if (i_lzc_stage.msb_set) begin
      // Product in [2,4), already aligned
      o_norm_stage.prod = i_lzc_stage.base.prod;
      o_norm_stage.exp  = i_lzc_stage.base.exp + 10'sd1;
    end else begin
      // Leading one moves up into bit 47
      o_norm_stage.prod = i_lzc_stage.base.prod << (i_lzc_stage.lzc + 6'd1);
      o_norm_stage.exp  = i_lzc_stage.base.exp - $signed({4'b0000, i_lzc_stage.lzc});
    end
  end

endmodule

//--- source/fmul_pack.sv
module fmul_pack (
  input  fmul_pkg::round_stage_t i_round,
  output fmul_pkg::fp32_t        o_result,
  output fmul_pkg::fp_flags_t    o_flags
);

  logic [24:0]    rounded;
  logic           carry;
  fmul_pkg::exp_t exp_adj;
  logic [22:0]    frac;
  logic           overflow;
  logic           underflow;
  logic           max_finite;

  assign rounded = {1'b0, i_round.mant} + {24'd0, i_round.round_up};
  assign carry   = rounded[24];

  always_comb begin
    if (carry) begin
      // Mantissa wrapped to 2.0, renormalize by one
      exp_adj = i_round.exp + 10'sd1;
      frac    = rounded[23:1];
    end else if (i_round.exp == 10'sd0 && rounded[23]) begin
      // Subnormal rounded up into the hidden bit
      exp_adj = 10'sd1;
      frac    = rounded[22:0];
    end else begin
      exp_adj = i_round.exp;
      frac    = rounded[22:0];
    end
  end

  assign overflow  = (exp_adj >= fmul_pkg::EXP_ALL_ONES);
  assign underflow = (exp_adj <= 10'sd0);

  // Modes that round toward zero at this sign saturate
  assign max_finite = (i_round.rm == fmul_pkg::RTZ) ||
                      (i_round.rm == fmul_pkg::RDN && !i_round.sign) ||
                      (i_round.rm == fmul_pkg::RUP && i_round.sign);

  // ======================================================================
  // Result select
  // ======================================================================

  always_comb begin
    o_result = '0;
    o_flags  = '0;

    if (i_round.special) begin
      o_result   = i_round.special_result;
      o_flags.nv = i_round.special_invalid;
    end else if (i_round.prod_zero) begin
      o_result = {i_round.sign, 31'd0};
    end else if (overflow) begin
      o_flags.of = 1'b1;
      o_flags.nx = 1'b1;
      if (max_finite) begin
        o_result = {i_round.sign, 8'hFE, 23'h7F_FFFF};
      end else begin
        o_result = {i_round.sign, 8'hFF, 23'd0};
      end
    end else if (underflow) begin
      // Tiny result, uf only when bits were lost
      o_flags.uf = i_round.inexact;
      o_flags.nx = i_round.inexact;
      o_result   = {i_round.sign, 8'h00, frac};
    end else begin
      o_flags.nx = i_round.inexact;
      o_result   = {i_round.sign, exp_adj[7:0], frac};
    end
  end

endmodule

//--- source/fmul_pkg.sv
package fmul_pkg;

  // ======================================================================
  // Vector types
  // ======================================================================

  // Single-precision word
  typedef logic [31:0] fp32_t;
  // Working exponent, signed, wide enough to go below zero or past 255
  typedef logic signed [9:0] exp_t;
  // Mantissa with the hidden bit on top
  typedef logic [23:0] mant_t;
  // Raw 24x24 product
  typedef logic [47:0] prod_t;
  // Leading-zero count over the product
  typedef logic [5:0] lzc_t;

  // Rounding mode, frm encoding
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } rm_e;

  // Exception flags in fflags order
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  // Sequencer, one state per stage register
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    STAGE1  = 3'd1,
    STAGE2  = 3'd2,
    STAGE3A = 3'd3,
    STAGE3B = 3'd4,
    STAGE4  = 3'd5,
    STAGE5  = 3'd6,
    STAGE6  = 3'd7
  } fmul_state_e;

  // ======================================================================
  // Stage contents
  // ======================================================================

  // After unpack, before the multiply
  typedef struct packed {
    logic  sign;
    exp_t  exp;
    mant_t mant_a;
    mant_t mant_b;
    logic  special;
    fp32_t special_result;
    logic  special_invalid;
    rm_e   rm;
  } unpack_stage_t;

  // After the multiply
  typedef struct packed {
    logic  sign;
    exp_t  exp;
    prod_t prod;
    logic  special;
    fp32_t special_result;
    logic  special_invalid;
    rm_e   rm;
  } product_stage_t;

  // Product plus its leading-zero information
  typedef struct packed {
    product_stage_t base;
    logic           prod_zero;
    logic           msb_set;
    lzc_t           lzc;
  } lzc_stage_t;

  // Leading one sits in bit 47 here
  typedef struct packed {
    logic  sign;
    exp_t  exp;
    prod_t prod;
    logic  prod_zero;
    logic  special;
    fp32_t special_result;
    logic  special_invalid;
    rm_e   rm;
  } norm_stage_t;

  // Mantissa ready for the increment
  typedef struct packed {
    logic  sign;
    exp_t  exp;
    mant_t mant;
    logic  round_up;
    logic  inexact;
    logic  prod_zero;
    rm_e   rm;
    logic  special;
    fp32_t special_result;
    logic  special_invalid;
  } round_stage_t;

  // ======================================================================
  // Format constants
  // ======================================================================

  localparam fp32_t CANONICAL_NAN = 32'h7FC0_0000;
  localparam exp_t  EXP_BIAS      = 10'sd127;
  localparam exp_t  EXP_ALL_ONES  = 10'sd255;
  // Mantissa plus guard, round and sticky
  localparam int    SHIFT_LIMIT   = 27;

endpackage

//--- source/fmul_round_decide.sv
module fmul_round_decide (
  input  fmul_pkg::norm_stage_t  i_norm,
  output fmul_pkg::round_stage_t o_round
);

  // Extended mantissa is {mant, guard, round, sticky}
  logic [fmul_pkg::SHIFT_LIMIT-1:0] ext;
  logic [fmul_pkg::SHIFT_LIMIT-1:0] ext_shifted;
  logic [fmul_pkg::SHIFT_LIMIT-1:0] lost_mask;
  logic signed [10:0]               shift_full;
  logic [5:0]                       shift_amt;
  logic                             shifted_lost;

  fmul_pkg::mant_t mant_w;
  fmul_pkg::exp_t  exp_w;
  logic            guard_w;
  logic            round_w;
  logic            sticky_w;
  logic            any_lost;
  logic            round_up;

  assign ext = {i_norm.prod[47:23], i_norm.prod[22], |i_norm.prod[21:0]};

  // Right shift that brings a tiny result up to exponent zero
  assign shift_full = 11'sd1 - $signed({i_norm.exp[9], i_norm.exp});
  assign shift_amt  = (shift_full >= fmul_pkg::SHIFT_LIMIT) ?
                      6'(fmul_pkg::SHIFT_LIMIT) : shift_full[5:0];

  // A shift of the full width clears the word and loses everything
  assign lost_mask    = ~({fmul_pkg::SHIFT_LIMIT{1'b1}} << shift_amt);
  assign ext_shifted  = ext >> shift_amt;
  assign shifted_lost = |(ext & lost_mask);

  always_comb begin
    // Normal range, bits straight from the product
    mant_w   = i_norm.prod[47:24];
    guard_w  = i_norm.prod[23];
    round_w  = i_norm.prod[22];
    sticky_w = |i_norm.prod[21:0];
    exp_w    = i_norm.exp;

    if (i_norm.exp <= 10'sd0) begin
      mant_w   = ext_shifted[26:3];
      guard_w  = ext_shifted[2];
      round_w  = ext_shifted[1];
      sticky_w = ext_shifted[0] | shifted_lost;
      exp_w    = '0;
    end
  end

  assign any_lost = guard_w | round_w | sticky_w;

  // ======================================================================
  // Round-up decision per mode
  // ======================================================================

  always_comb begin
    case (i_norm.rm)
      fmul_pkg::RNE: round_up = guard_w & (round_w | sticky_w | mant_w[0]);
      fmul_pkg::RTZ: round_up = 1'b0;
      fmul_pkg::RDN: round_up = i_norm.sign & any_lost;
      fmul_pkg::RUP: round_up = ~i_norm.sign & any_lost;
      fmul_pkg::RMM: round_up = guard_w;
      // Reserved codes behave as RNE
      default:       round_up = guard_w & (round_w | sticky_w | mant_w[0]);
    endcase
  end

  always_comb begin
    o_round.sign            = i_norm.sign;
    o_round.exp             = exp_w;
    o_round.mant            = mant_w;
    o_round.round_up        = round_up;
    o_round.inexact         = any_lost;
    o_round.prod_zero       = i_norm.prod_zero;
    o_round.rm              = i_norm.rm;
    o_round.special         = i_norm.special;
    o_round.special_result  = i_norm.special_result;
    o_round.special_invalid = i_norm.special_invalid;
  end

endmodule

//--- source/fmul_top.sv
module fmul_top (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_valid,
  input  fmul_pkg::fp32_t     i_operand_a,
  input  fmul_pkg::fp32_t     i_operand_b,
  input  fmul_pkg::rm_e       i_rounding_mode,
  output fmul_pkg::fp32_t     o_result,
  output fmul_pkg::fp_flags_t o_flags,
  output logic                o_valid
);

  // ======================================================================
  // Sequencer
  // ======================================================================

  fmul_pkg::fmul_state_e state;
  fmul_pkg::fmul_state_e next_state;

  // Strobe delay line behind STAGE6
  logic [1:0] valid_pipe;

  always_comb begin
    next_state = state;
    case (state)
      fmul_pkg::IDLE:    if (i_valid) next_state = fmul_pkg::STAGE1;
      fmul_pkg::STAGE1:  next_state = fmul_pkg::STAGE2;
      fmul_pkg::STAGE2:  next_state = fmul_pkg::STAGE3A;
      fmul_pkg::STAGE3A: next_state = fmul_pkg::STAGE3B;
      fmul_pkg::STAGE3B: next_state = fmul_pkg::STAGE4;
      fmul_pkg::STAGE4:  next_state = fmul_pkg::STAGE5;
      fmul_pkg::STAGE5:  next_state = fmul_pkg::STAGE6;
      fmul_pkg::STAGE6:  next_state = fmul_pkg::IDLE;
      default:           next_state = fmul_pkg::IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= fmul_pkg::IDLE;
      valid_pipe <= '0;
    end else begin
      state      <= next_state;
      // o_valid rises one edge after the STAGE6 edge
      valid_pipe <= {valid_pipe[0], state == fmul_pkg::STAGE6};
    end
  end

  assign o_valid = valid_pipe[1];

  // ======================================================================
  // Operand capture and stage registers
  // ======================================================================

  fmul_pkg::fp32_t op_a_q;
  fmul_pkg::fp32_t op_b_q;
  fmul_pkg::rm_e   rm_q;

  fmul_pkg::unpack_stage_t  unpack_d;
  fmul_pkg::unpack_stage_t  s2_q;
  fmul_pkg::product_stage_t product_d;
  fmul_pkg::product_stage_t s3_q;
  fmul_pkg::lzc_stage_t     lzc_d;
  fmul_pkg::lzc_stage_t     s3b_q;
  fmul_pkg::norm_stage_t    norm_d;
  fmul_pkg::norm_stage_t    s4_q;
  fmul_pkg::round_stage_t   round_d;
  fmul_pkg::round_stage_t   s5_q;
  fmul_pkg::fp32_t          result_d;
  fmul_pkg::fp_flags_t      flags_d;

  fmul_unpack fmul_unpack_inst (
    .i_op_a  (op_a_q),
    .i_op_b  (op_b_q),
    .i_rm    (rm_q),
    .o_stage (unpack_d)
  );

  // Mantissa multiply between stage 2 and stage 3
  always_comb begin
    product_d.sign            = s2_q.sign;
    product_d.exp             = s2_q.exp;
    product_d.prod            = s2_q.mant_a * s2_q.mant_b;
    product_d.special         = s2_q.special;
    product_d.special_result  = s2_q.special_result;
    product_d.special_invalid = s2_q.special_invalid;
    product_d.rm              = s2_q.rm;
  end

  fmul_normalize fmul_normalize_inst (
    .i_product    (s3_q),
    .o_lzc_stage  (lzc_d),
    .i_lzc_stage  (s3b_q),
    .o_norm_stage (norm_d)
  );

  fmul_round_decide fmul_round_decide_inst (
    .i_norm  (s4_q),
    .o_round (round_d)
  );

  fmul_pack fmul_pack_inst (
    .i_round  (s5_q),
    .o_result (result_d),
    .o_flags  (flags_d)
  );

  // Each register loads only in its own state
  always_ff @(posedge i_clk) begin
    case (state)
      fmul_pkg::IDLE: begin
        if (i_valid) begin
          op_a_q <= i_operand_a;
          op_b_q <= i_operand_b;
          rm_q   <= i_rounding_mode;
        end
      end
      fmul_pkg::STAGE1:  s2_q  <= unpack_d;
      fmul_pkg::STAGE2:  s3_q  <= product_d;
      fmul_pkg::STAGE3A: s3b_q <= lzc_d;
      fmul_pkg::STAGE3B: s4_q  <= norm_d;
      fmul_pkg::STAGE4:  s5_q  <= round_d;
      default: ;
    endcase
  end

  // ======================================================================
  // Output registers
  // ======================================================================

  // Result holds until the next operation reaches STAGE5
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_result <= '0;
      o_flags  <= '0;
    end else if (state == fmul_pkg::STAGE5) begin
      o_result <= result_d;
      o_flags  <= flags_d;
    end
  end

endmodule

//--- source/fmul_unpack.sv
module fmul_unpack (
  input  fmul_pkg::fp32_t         i_op_a,
  input  fmul_pkg::fp32_t         i_op_b,
  input  fmul_pkg::rm_e           i_rm,
  output fmul_pkg::unpack_stage_t o_stage
);

  // Per-operand view after classing
  typedef struct packed {
    logic [7:0]      exp;
    fmul_pkg::mant_t mant;
    logic            zero;
    logic            inf;
    logic            nan;
    logic            snan;
  } operand_t;

  function automatic operand_t classify(input fmul_pkg::fp32_t op);
    operand_t c;
    logic     exp_zero;
    logic     exp_ones;
    logic     frac_zero;
    exp_zero  = (op[30:23] == 8'h00);
    exp_ones  = (op[30:23] == 8'hFF);
    frac_zero = (op[22:0] == 23'd0);
    // Subnormal counts as exponent 1 with a clear hidden bit
    c.exp  = exp_zero ? 8'd1 : op[30:23];
    c.mant = {~exp_zero, op[22:0]};
    c.zero = exp_zero & frac_zero;
    c.inf  = exp_ones & frac_zero;
    c.nan  = exp_ones & ~frac_zero;
    // Quiet bit clear marks a signaling NaN
    c.snan = exp_ones & ~frac_zero & ~op[22];
    return c;
  endfunction

  operand_t a;
  operand_t b;
  logic     sign;

  assign a    = classify(i_op_a);
  assign b    = classify(i_op_b);
  assign sign = i_op_a[31] ^ i_op_b[31];

  always_comb begin
    o_stage.sign   = sign;
    // Biased exponents add, so one bias comes back out
    o_stage.exp    = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - fmul_pkg::EXP_BIAS;
    o_stage.mant_a = a.mant;
    o_stage.mant_b = b.mant;
    o_stage.rm     = i_rm;

    o_stage.special         = 1'b0;
    o_stage.special_result  = '0;
    o_stage.special_invalid = 1'b0;

    // Priority: NaN, inf*0, inf, zero
    if (a.nan || b.nan) begin
      o_stage.special         = 1'b1;
      o_stage.special_result  = fmul_pkg::CANONICAL_NAN;
      o_stage.special_invalid = a.snan | b.snan;
    end else if ((a.inf && b.zero) || (a.zero && b.inf)) begin
      o_stage.special         = 1'b1;
      o_stage.special_result  = fmul_pkg::CANONICAL_NAN;
      o_stage.special_invalid = 1'b1;
    end else if (a.inf || b.inf) begin
      o_stage.special        = 1'b1;
      o_stage.special_result = {sign, 8'hFF, 23'd0};
    end else if (a.zero || b.zero) begin
      // Signed zero, sign is the xor as usual
      o_stage.special        = 1'b1;
      o_stage.special_result = {sign, 31'd0};
    end
  end

endmodule

//--- verif/fmul_stimulus.txt
// operand_a operand_b rm result flags, all hex; rm 0..4 is RNE RTZ RDN RUP RMM
// flags are {nv, dz, of, uf, nx}
3F800000 3F800000 0 3F800000 00
3FC00000 40000000 0 40400000 00
C0200000 40800000 0 C1200000 00
40400000 3F000000 0 3FC00000 00
3FC00000 3FC00000 0 40100000 00
3F800001 3F800001 0 3F800002 01
3F800001 3FC00000 0 3FC00002 01
3F800003 3FC00000 0 3FC00004 01
BF800001 3FC00001 0 BFC00003 01
BF800001 3FC00001 1 BFC00002 01
BF800001 3FC00001 2 BFC00003 01
BF800001 3FC00001 3 BFC00002 01
BF800001 3FC00001 4 BFC00003 01
7F000000 40000000 0 7F800000 05
7F000000 40000000 1 7F7FFFFF 05
7F000000 40000000 2 7F7FFFFF 05
FF000000 40000000 3 FF7FFFFF 05
FF000000 40000000 4 FF800000 05
7FC12345 3F800000 0 7FC00000 00
7F800001 3F800000 0 7FC00000 10
40000000 FFA00000 0 7FC00000 10
7F800000 00000000 0 7FC00000 10
7F800000 C0000000 0 FF800000 00
80000000 40A00000 0 80000000 00
80000000 C0400000 0 00000000 00
00400000 40800000 0 01000000 00
00800000 3F000000 0 00400000 00
00800001 3F000000 0 00400000 03
00800001 3F000000 3 00400001 03
00000001 3F000000 0 00000000 03
80000001 3F000000 2 80000001 03
00000001 00000001 3 00000001 03

//--- verif/fmul_tb.sv
module fmul_tb;

  // ======================================================================
  // Timing and limits
  // ======================================================================

  localparam int          CLK_PERIOD  = 4;
  localparam int          DRIVE_DELAY = 1;
  // Edges from the accepting edge to the first cycle with o_valid high
  localparam int          LATENCY     = 8;
  localparam int          WAIT_LIMIT  = 20;
  localparam logic [15:0] LFSR_SEED   = 16'd65;

  logic                clk;
  logic                rst;
  logic                valid;
  fmul_pkg::fp32_t     operand_a;
  fmul_pkg::fp32_t     operand_b;
  fmul_pkg::rm_e       rounding_mode;
  fmul_pkg::fp32_t     result;
  fmul_pkg::fp_flags_t flags;
  logic                result_valid;

  // Vectors from the stimulus file
  logic [31:0] vec_a[$];
  logic [31:0] vec_b[$];
  logic [2:0]  vec_rm[$];
  logic [31:0] vec_result[$];
  logic [31:0] vec_flags[$];

  int          vec_count      = 0;
  logic        vectors_loaded = 1'b0;
  logic        load_ok;
  int          error_count    = 0;
  int          check_count    = 0;
  int          pulse_count    = 0;
  logic [15:0] lfsr_state;

  fmul_top fmul_top_inst (
    .i_clk           (clk),
    .i_rst           (rst),
    .i_valid         (valid),
    .i_operand_a     (operand_a),
    .i_operand_b     (operand_b),
    .i_rounding_mode (rounding_mode),
    .o_result        (result),
    .o_flags         (flags),
    .o_valid         (result_valid)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Counted mid-cycle where o_valid is stable
  always @(negedge clk) begin
    if (!rst && result_valid) begin
      pulse_count++;
    end
  end

  // ======================================================================
  // Helpers
  // ======================================================================

  // Galois LFSR over x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hB400;
    end
    return next;
  endfunction

  // One LFSR step per bit taken
  task automatic take_random_bits(input int width, output int value);
    value = 0;
    for (int i = 0; i < width; i++) begin
      value = value * 2 + (lfsr_state[0] ? 1 : 0);
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error at time %0t: %s is %h, expected %h",
               $time, what, actual, expected);
    end
  endtask

  // Each line holds a, b, mode, result and flags in hex
  // Lines that start with a slash are comments
  task automatic load_vectors(output logic ok);
    int          fd;
    int          fields;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rm;
    logic [31:0] res;
    logic [31:0] fl;
    ok = 1'b0;
    fd = $fopen("verif/fmul_stimulus.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != "/") begin
          fields = $sscanf(line, "%h %h %h %h %h", a, b, rm, res, fl);
          if (fields == 5) begin
            vec_a.push_back(a);
            vec_b.push_back(b);
            vec_rm.push_back(rm[2:0]);
            vec_result.push_back(res);
            vec_flags.push_back(fl);
          end
        end
      end
      $fclose(fd);
      vec_count = vec_a.size();
      ok = (vec_count > 0);
    end
  endtask

  // One request, an optional busy-time request, then the result
  task automatic run_vector(input int idx);
    int   gap;
    int   latency;
    logic busy_request;
    take_random_bits(2, gap);
    busy_request = (idx % 2 == 1);
    repeat (gap) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    valid         = 1'b1;
    operand_a     = vec_a[idx];
    operand_b     = vec_b[idx];
    rounding_mode = fmul_pkg::rm_e'(vec_rm[idx]);
    // Accepting edge
    @(posedge clk);
    #DRIVE_DELAY;
    valid   = 1'b0;
    latency = 0;
    while (!result_valid && latency < WAIT_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      latency++;
      // Sampled on the third edge after acceptance while busy
      if (busy_request && latency == 2) begin
        valid         = 1'b1;
        operand_a     = 32'h4049_0FDB;
        operand_b     = 32'hC000_0000;
        rounding_mode = fmul_pkg::RUP;
      end else begin
        valid = 1'b0;
      end
    end
    if (!result_valid) begin
      error_count++;
      $display("Vector %0d got no o_valid within %0d cycles", idx, WAIT_LIMIT);
    end else begin
      check_value($sformatf("vector %0d latency", idx), latency, LATENCY);
      check_value($sformatf("vector %0d o_result", idx), result, vec_result[idx]);
      check_value($sformatf("vector %0d o_flags", idx), 32'(flags), vec_flags[idx]);
    end
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial begin
    rst           = 1'b1;
    valid         = 1'b0;
    operand_a     = '0;
    operand_b     = '0;
    rounding_mode = fmul_pkg::RNE;
    lfsr_state    = LFSR_SEED;
    load_vectors(load_ok);
    if (!load_ok) begin
      $display("Stimulus file verif/fmul_stimulus.txt is missing or holds no vectors");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      vectors_loaded = 1'b1;
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
      repeat (3) @(posedge clk);
      #DRIVE_DELAY;
      // Nothing requested yet
      check_value("o_valid pulses before the first request", pulse_count, 0);
      check_value("o_result after reset", result, 32'd0);
      check_value("o_flags after reset", 32'(flags), 32'd0);
      for (int k = 0; k < vec_count; k++) begin
        run_vector(k);
      end
      repeat (4) @(posedge clk);
      // Busy-time requests must not add pulses
      check_value("o_valid pulse count", pulse_count, vec_count);
      $display("Vectors: %0d, checks: %0d, errors: %0d", vec_count, check_count, error_count);
      if (error_count == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

  // Watchdog sized from the vector count
  initial begin
    wait (vectors_loaded);
    repeat (vec_count * 16 + 100) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not complete",
             vec_count * 16 + 100);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
